//--- dma_debug.f
src/dma_debug_pkg.sv
src/debug_checker.sv
src/dma_engine.sv
src/dma_memory.sv
src/dma_debug_top.sv
dv/dma_debug_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dma_debug_tb
FILELIST  ?= dma_debug.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

SRCS := $(wildcard src/*.sv) $(wildcard dv/*.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# simulator binary, rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/dma_debug_tb.sv
// testbench with clock, reset, memory load, debug request stimulus, reference model and report

`timescale 1ns/1ns

module dma_debug_tb
	import dma_debug_pkg::*;
();

	localparam int mem_words       = 256;
	localparam int n_directed      = 17;
	localparam int n_random        = 200;
	localparam int n_requests      = n_directed + n_random;
	localparam int watchdog_cycles = n_requests * 20 + 600;

	logic        clk;
	logic        reset;
	logic        debug_val;
	debug_req_t  debug_req;
	logic        dma_domain;
	mem_wr_t     host_wr;
	logic        debug_ack;
	debug_resp_t debug_resp;

	// shadow of the DUT memory, plus what each outstanding request should give
	logic [data_w-1:0] shadow [mem_words];
	debug_resp_t       want_q[$];
	int                lat_q[$];
	int                start_q[$];

	int     cycle  = 0;
	int     errors = 0;
	int     acks   = 0;
	int     sent   = 0;
	integer seed   = 32'h5470_3080;

	dma_debug_top #(.p_mem_words(mem_words)) uut (.clk, .reset, .debug_val, .debug_req,
		.dma_domain, .host_wr, .debug_ack, .debug_resp);

	// ----------------------------------------------------------
	// clock and cycle count
	// ----------------------------------------------------------

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// read at the falling edge only
	always @(posedge clk)
		cycle <= cycle + 1;

	// ----------------------------------------------------------
	// reference model
	// ----------------------------------------------------------

	// lower request domain than the engine is refused with a zero word
	function automatic debug_resp_t expected_resp(input debug_req_t req, input logic domain);
		debug_resp_t resp;
		resp = '0;
		if (!(req.domain == 1'b0 && domain == 1'b1)) begin
			resp.granted = 1'b1;
			// read and copy both return the source word
			resp.data = shadow[req.src_addr % mem_words];
		end
		return resp;
	endfunction

	// cycles from debug_val to debug_ack
	function automatic int expected_latency(input debug_req_t req, input logic domain);
		if (req.domain == 1'b0 && domain == 1'b1)
			return 2;
		else if (req.op == op_copy)
			return 6;
		else
			return 5;
	endfunction

	function automatic debug_req_t make_req(input logic domain, input dma_op_e op,
		input logic [addr_w-1:0] src, input logic [addr_w-1:0] dest);
		debug_req_t req;
		req.domain    = domain;
		req.op        = op;
		req.src_addr  = src;
		req.dest_addr = dest;
		return req;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		if (got !== want) begin
			$display("ERR %s got %h expected %h", name, got, want);
			errors++;
		end
	endtask

	// ----------------------------------------------------------
	// stimulus tasks
	// ----------------------------------------------------------

	// random fill through the host port, mirrored in the shadow
	task automatic load_memory();
		logic [31:0] rnd;
		for (int i = 0; i < mem_words; i++) begin
			rnd = $random(seed);
			@(posedge clk);
			host_wr <= '{en: 1'b1, addr: 32'(i), data: rnd};
			shadow[i] = rnd;
		end
		@(posedge clk);
		host_wr <= '0;
	endtask

	// domain only moves here, with the checker idle
	task automatic send_request(input logic domain, input debug_req_t req);
		debug_resp_t want;
		int          waited;
		@(posedge clk);
		want = expected_resp(req, domain);
		want_q.push_back(want);
		lat_q.push_back(expected_latency(req, domain));
		dma_domain <= domain;
		debug_val  <= 1'b1;
		debug_req  <= req;
		// granted copy moves the source word to the destination
		if (want.granted && req.op == op_copy)
			shadow[req.dest_addr % mem_words] = want.data;
		@(negedge clk);
		start_q.push_back(cycle);
		@(posedge clk);
		debug_val <= 1'b0;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!debug_ack && waited < 20);
		if (!debug_ack) begin
			$display("no debug_ack within 20 cycles of request %0d", sent);
			errors++;
		end
		sent++;
	endtask

	// ----------------------------------------------------------
	// response compare
	// ----------------------------------------------------------

	always @(negedge clk) begin : compare_resp
		debug_resp_t want;
		int          lat;
		if (!reset && debug_ack) begin
			acks++;
			if (want_q.size() == 0) begin
				$display("debug_ack arrived with no request outstanding");
				errors++;
			end else begin
				want = want_q.pop_front();
				lat  = cycle - start_q.pop_front();
				check_value("debug_resp.granted", 64'(debug_resp.granted), 64'(want.granted));
				check_value("debug_resp.data", 64'(debug_resp.data), 64'(want.data));
				check_value("debug_ack latency", 64'(lat), 64'(lat_q.pop_front()));
			end
		end
	end

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------

	initial begin
		logic [31:0] rnd;
		logic [31:0] rnd_addr;
		reset      = 1'b1;
		debug_val  = 1'b0;
		debug_req  = '0;
		dma_domain = 1'b0;
		host_wr    = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		load_memory();

		// equal domain reads
		send_request(1'b0, make_req(1'b0, op_read, 32'd3, 32'd0));
		send_request(1'b0, make_req(1'b0, op_read, 32'd200, 32'd0));
		send_request(1'b1, make_req(1'b1, op_read, 32'd17, 32'd0));
		send_request(1'b1, make_req(1'b1, op_read, 32'd255, 32'd0));

		// normal requests against a secure engine, destination must stay
		send_request(1'b1, make_req(1'b0, op_copy, 32'd5, 32'd40));
		send_request(1'b1, make_req(1'b0, op_read, 32'd5, 32'd0));
		send_request(1'b1, make_req(1'b1, op_read, 32'd40, 32'd0));

		// secure copy, then read back the destination
		send_request(1'b1, make_req(1'b1, op_copy, 32'd9, 32'd77));
		send_request(1'b1, make_req(1'b1, op_read, 32'd77, 32'd0));

		// back to back, every domain pair and both ops
		for (int i = 0; i < 8; i++) begin
			send_request(i[1], make_req(i[0], i[2] ? op_copy : op_read,
				32'(i * 31 + 2), 32'(100 + i)));
		end

		// random mix, idle gaps of 0 to 3 cycles
		for (int i = 0; i < n_random; i++) begin
			rnd      = $random(seed);
			rnd_addr = $random(seed);
			repeat (rnd[3:2]) @(posedge clk);
			send_request(rnd[4], make_req(rnd[0], rnd[1] ? op_copy : op_read,
				32'(rnd_addr[15:0]) % mem_words, 32'(rnd_addr[31:16]) % mem_words));
		end

		repeat (2) @(posedge clk);
		$display("requests %0d, responses %0d, errors %0d", sent, acks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// ----------------------------------------------------------
	// watchdog
	// ----------------------------------------------------------

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("run did not complete within %0d cycles", watchdog_cycles);
		$display("Checks failed");
		$finish;
	end

endmodule

//--- src/dma_debug_top.sv
// top level joining the debug checker, DMA engine and word memory

`timescale 1ns/1ns

module dma_debug_top
	import dma_debug_pkg::*;
#(
	parameter int p_mem_words = 256
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic        debug_val,
	input  debug_req_t  debug_req,
	input  logic        dma_domain,	// level, current engine domain
	input  mem_wr_t     host_wr,
	output logic        debug_ack,
	output debug_resp_t debug_resp
);

	// ----------------------------------------------------------
	// internal wires
	// ----------------------------------------------------------

	// checker to engine
	logic              dma_val;
	dma_req_t          dma_req;
	logic              dma_ack;
	logic [data_w-1:0] dma_data;

	// engine to memory
	logic [addr_w-1:0] rd_addr;
	logic [data_w-1:0] rd_data;
	mem_wr_t           eng_wr;

	debug_checker u_checker (.clk, .reset, .debug_val, .debug_req, .debug_ack,
		.debug_resp, .dma_domain, .dma_ack, .dma_data, .dma_val, .dma_req);

	dma_engine u_engine (.clk, .reset, .dma_val, .dma_req, .dma_ack, .dma_data,
		.rd_addr, .rd_data, .eng_wr);

	dma_memory #(.p_mem_words(p_mem_words)) u_memory (.clk, .host_wr, .eng_wr,
		.rd_addr, .rd_data);

endmodule

//--- src/dma_memory.sv
// word memory with registered read and shared host and engine write port

`timescale 1ns/1ns

module dma_memory
	import dma_debug_pkg::*;
#(
	parameter int p_mem_words = 256
)
(
	input  logic              clk,

	// write sources, at most one per cycle
	input  mem_wr_t           host_wr,
	input  mem_wr_t           eng_wr,

	// read port
	input  logic [addr_w-1:0] rd_addr,
	output logic [data_w-1:0] rd_data
);

	// index width from the depth
	localparam int idx_w = $clog2(p_mem_words);

	logic [data_w-1:0] mem [p_mem_words];
	mem_wr_t           wr;

	// ----------------------------------------------------------
	// write select
	// ----------------------------------------------------------

	// host load wins the mux, both never fire together
	assign wr = host_wr.en ? host_wr : eng_wr;

	// ----------------------------------------------------------
	// array access
	// ----------------------------------------------------------

	always_ff @(posedge clk) begin
		if (wr.en)
			mem[wr.addr[idx_w-1:0]] <= wr.data;
		// read sees the old word on a same address write
		rd_data <= mem[rd_addr[idx_w-1:0]];
	end

	// loading ends before any debug traffic reaches the engine
	a_one_writer: assert property (@(posedge clk)
		!(host_wr.en === 1'b1 && eng_wr.en === 1'b1));

endmodule

//--- src/dma_engine.sv
// DMA sequencer for read and copy operations against the word memory

`timescale 1ns/1ns

module dma_engine
	import dma_debug_pkg::*;
(
	input  logic              clk,
	input  logic              reset,

	// request from the checker
	input  logic              dma_val,
	input  dma_req_t          dma_req,
	output logic              dma_ack,
	output logic [data_w-1:0] dma_data,

	// memory side
	output logic [addr_w-1:0] rd_addr,
	input  logic [data_w-1:0] rd_data,
	output mem_wr_t           eng_wr
);

	// ----------------------------------------------------------
	// sequencer state
	// ----------------------------------------------------------

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_write,
		st_ack
	} state_e;

	state_e state;
	state_e state_next;

	dma_op_e           op_reg;
	logic [addr_w-1:0] dest_reg;
	logic [data_w-1:0] word_reg;

	always_ff @(posedge clk) begin
		if (reset)
			state <= st_idle;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			st_idle: if (dma_val) state_next = st_read;
			// read word arrives here, copy still has a write to do
			st_read:  state_next = (op_reg == op_copy) ? st_write : st_ack;
			st_write: state_next = st_ack;
			st_ack:   state_next = st_idle;
			default:  state_next = st_idle;
		endcase
	end

	// ----------------------------------------------------------
	// operation and word registers
	// ----------------------------------------------------------

	// op and destination taken with the request
	always_ff @(posedge clk) begin
		if (state == st_idle && dma_val) begin
			op_reg   <= dma_req.op;
			dest_reg <= dma_req.dest_addr;
		end
	end

	// memory answers one cycle after the address
	always_ff @(posedge clk) begin
		if (state == st_read)
			word_reg <= rd_data;
	end

	// ----------------------------------------------------------
	// memory access
	// ----------------------------------------------------------

	// source address stays stable in the checker's capture
	// register, so the read goes out in the dma_val cycle
	assign rd_addr = dma_req.src_addr;

	// copy writes the held word back at the destination
	always_comb begin
		eng_wr.en   = (state == st_write);
		eng_wr.addr = dest_reg;
		eng_wr.data = word_reg;
	end

	// ----------------------------------------------------------
	// acknowledge
	// ----------------------------------------------------------

	assign dma_ack  = (state == st_ack);
	assign dma_data = word_reg;

	// checker must not issue a second request mid operation
	a_val_when_idle: assert property (@(posedge clk) disable iff (reset)
		dma_val |-> state == st_idle);

endmodule

//--- src/debug_checker.sv
// debug request capture, security domain check and response return FSM

`timescale 1ns/1ns

module debug_checker
	import dma_debug_pkg::*;
(
	input  logic              clk,
	input  logic              reset,

	// debug port side
	input  logic              debug_val,
	input  debug_req_t        debug_req,
	output logic              debug_ack,
	output debug_resp_t       debug_resp,

	// engine side
	input  logic              dma_domain,
	input  logic              dma_ack,
	input  logic [data_w-1:0] dma_data,
	output logic              dma_val,
	output dma_req_t          dma_req
);

	// ----------------------------------------------------------
	// state register
	// ----------------------------------------------------------

	typedef enum logic [2:0] {
		st_idle,
		st_check,
		st_request,
		st_wait,
		st_respond
	} state_e;

	state_e state;
	state_e state_next;

	debug_req_t  req_reg;
	debug_resp_t resp_reg;
	logic        grant;

	always_ff @(posedge clk) begin
		if (reset)
			state <= st_idle;
		else
			state <= state_next;
	end

	// equal or higher domain may reach the engine
	assign grant = (req_reg.domain >= dma_domain);

	// ----------------------------------------------------------
	// next state
	// ----------------------------------------------------------

	always_comb begin
		state_next = state;
		case (state)
			// strobes while busy are simply dropped
			st_idle:    if (debug_val) state_next = st_check;
			st_check:   state_next = grant ? st_request : st_respond;
			st_request: state_next = st_wait;
			st_wait:    if (dma_ack) state_next = st_respond;
			st_respond: state_next = st_idle;
			default:    state_next = st_idle;
		endcase
	end

	// captured request, held until the next accepted strobe
	always_ff @(posedge clk) begin
		if (state == st_idle && debug_val)
			req_reg <= debug_req;
	end

	// response word, refusal set in check, engine word on ack
	always_ff @(posedge clk) begin
		if (reset)
			resp_reg <= '0;
		else if (state == st_check && !grant)
			resp_reg <= '0;
		else if (state == st_wait && dma_ack)
			resp_reg <= '{granted: 1'b1, data: dma_data};
	end

	// ----------------------------------------------------------
	// outputs
	// ----------------------------------------------------------

	assign dma_val    = (state == st_request);
	assign dma_req    = '{op: req_reg.op, src_addr: req_reg.src_addr,
	                      dest_addr: req_reg.dest_addr};
	assign debug_ack  = (state == st_respond);
	assign debug_resp = resp_reg;

	// engine only answers a forwarded request
	a_ack_in_wait: assert property (@(posedge clk) disable iff (reset)
		dma_ack |-> state == st_wait);

endmodule

//--- src/dma_debug_pkg.sv
// shared widths, operation code and the request, response and memory write structs

package dma_debug_pkg;

	// ----------------------------------------------------------
	// widths
	// ----------------------------------------------------------

	// address and word widths of every struct below
	parameter int addr_w = 32;
	parameter int data_w = 32;

	// ----------------------------------------------------------
	// operation code
	// ----------------------------------------------------------

	typedef enum logic {
		op_read = 1'b0,	// return the source word
		op_copy = 1'b1	// source word to destination, then return it
	} dma_op_e;

	// ----------------------------------------------------------
	// transfer structs
	// ----------------------------------------------------------

	// request as seen on the debug port
	typedef struct packed {
		logic              domain;	// 0 normal, 1 secure
		dma_op_e           op;
		logic [addr_w-1:0] src_addr;
		logic [addr_w-1:0] dest_addr;
	} debug_req_t;

	// request after the domain check, domain dropped
	typedef struct packed {
		dma_op_e           op;
		logic [addr_w-1:0] src_addr;
		logic [addr_w-1:0] dest_addr;
	} dma_req_t;

	// answer back to the debug port
	typedef struct packed {
		logic              granted;
		logic [data_w-1:0] data;	// zero on refusal
	} debug_resp_t;

	// one memory write, host load or engine
	typedef struct packed {
		logic              en;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] data;
	} mem_wr_t;

endpackage
